// ==== udp_tx_pkg.sv ====
package udp_tx_pkg;

    // Payload carried by every datagram, in bytes
    localparam int payload_bytes = 16;

    // System clock cycles per PHY reference clock period
    localparam int phy_divider = 4;
    localparam int phy_count_bits = $clog2(phy_divider);

    // Fifteen preamble nibbles and the SFD nibble
    localparam int preamble_nibbles = 16;

    // Interframe gap, counted in transmit clock periods (12 octets)
    localparam int gap_nibbles = 24;

    // Header sizes in bytes
    localparam int eth_header_bytes = 14;
    localparam int ip_header_bytes = 20;
    localparam int udp_header_bytes = 8;

    // Everything between the SFD and the FCS
    localparam int frame_bytes = eth_header_bytes + ip_header_bytes + udp_header_bytes +
        payload_bytes;
    localparam int frame_nibbles = 2 * frame_bytes;

    // One counter in the serializer covers the longest phase, which is the frame
    localparam int nibble_count_bits = $clog2(frame_nibbles);

    // Length fields as carried in the IPv4 and UDP headers
    localparam logic [15:0] ip_total_length =
        16'(ip_header_bytes + udp_header_bytes + payload_bytes);
    localparam logic [15:0] udp_length = 16'(udp_header_bytes + payload_bytes);

    // Fixed protocol values
    localparam logic [15:0] ether_type_ipv4 = 16'h0800;
    localparam logic [3:0] ip_version = 4'd4;
    localparam logic [3:0] ip_ihl = 4'(ip_header_bytes / 4);
    // Asks for high throughput and high reliability
    localparam logic [7:0] ip_tos = 8'h0C;
    localparam logic [7:0] ip_ttl = 8'hFF;
    localparam logic [7:0] ip_proto_udp = 8'h11;

    // Ethernet CRC-32 polynomial in its bit-reversed form
    localparam logic [31:0] crc_polynomial = 32'hEDB88320;

    // Ethernet MAC header, sent from the top bit down
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] ether_type;
    } eth_header_t;

    // IPv4 header in RFC 791 field order
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_header_t;

    // UDP header in RFC 768 field order
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // Addresses and ports of both ends of the datagram
    typedef struct packed {
        logic [31:0] src_ip;
        logic [47:0] src_mac;
        logic [15:0] src_port;
        logic [31:0] dest_ip;
        logic [47:0] dest_mac;
        logic [15:0] dest_port;
    } endpoint_t;

    // The first payload byte sits in the top eight bits
    typedef logic [8*payload_bytes-1:0] payload_t;

    typedef struct packed {
        endpoint_t endpoint;
        payload_t  payload;
    } udp_request_t;

    // A complete frame without preamble and FCS, first byte on the wire at the top
    typedef struct packed {
        eth_header_t eth_header;
        ip_header_t  ip_header;
        udp_header_t udp_header;
        payload_t    payload;
    } frame_t;

endpackage

// ==== phy_clk_gen.sv ====
`timescale 1ns/1ps

module phy_clk_gen (
    input  logic clk,
    input  logic reset,
    output logic ref_clk
);

    import udp_tx_pkg::*;

    logic [phy_count_bits-1:0] count;
    logic [phy_count_bits-1:0] count_next;

    // Free-running count that wraps after phy_divider cycles
    always_comb begin
        if (count == phy_count_bits'(phy_divider - 1)) begin
            count_next = '0;
        end else begin
            count_next = count + 1'b1;
        end
    end

    // The clock is registered from the next count so that it is low while the
    // count is in its lower half and high while it is in its upper half
    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            ref_clk <= 1'b0;
        end else begin
            count   <= count_next;
            ref_clk <= (count_next >= phy_count_bits'(phy_divider / 2));
        end
    end

endmodule

// ==== frame_builder.sv ====
`timescale 1ns/1ps

module frame_builder (
    input  logic                    clk,
    input  logic                    reset,
    input  udp_tx_pkg::udp_request_t req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output udp_tx_pkg::frame_t      frame,
    output logic                    frame_valid,
    input  logic                    frame_ready
);

    import udp_tx_pkg::*;

    // Idle, sum the header words, write the checksum, offer the frame
    typedef enum logic [1:0] {
        fb_idle,
        fb_sum,
        fb_check,
        fb_valid
    } fb_state_t;

    fb_state_t  state;
    frame_t     frame_q;
    logic [19:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_sum;
    logic [15:0] sum_q;
    logic       accept;

    assign accept = req_valid && req_ready;

    // Only one frame is held, so nothing new is taken until it has been handed on
    assign req_ready = (state == fb_idle);
    assign frame_valid = (state == fb_valid);
    assign frame = frame_q;

    // Ten 16-bit words fit in 20 bits; two folds bring the carries back around
    always_comb begin
        word_sum = '0;
        for (int w = 0; w < ip_header_bytes / 2; w++) begin
            word_sum = word_sum + 20'(frame_q.ip_header[16*w +: 16]);
        end
        fold_once = {1'b0, word_sum[15:0]} + 17'(word_sum[19:16]);
        fold_sum = fold_once[15:0] + 16'(fold_once[16]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fb_idle;
        end else begin
            case (state)
                fb_idle:  if (accept) state <= fb_sum;
                fb_sum:   state <= fb_check;
                fb_check: state <= fb_valid;
                fb_valid: if (frame_ready) state <= fb_idle;
                default:  state <= fb_idle;
            endcase
        end
    end

    // The request fills the frame, then the sum and its complement follow one cycle apart
    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q.eth_header.dest_mac        <= req.endpoint.dest_mac;
            frame_q.eth_header.src_mac         <= req.endpoint.src_mac;
            frame_q.eth_header.ether_type      <= ether_type_ipv4;
            frame_q.ip_header.version          <= ip_version;
            frame_q.ip_header.ihl              <= ip_ihl;
            frame_q.ip_header.type_of_service  <= ip_tos;
            frame_q.ip_header.total_length     <= ip_total_length;
            frame_q.ip_header.identification   <= '0;
            frame_q.ip_header.flags            <= '0;
            frame_q.ip_header.fragment_offset  <= '0;
            frame_q.ip_header.time_to_live     <= ip_ttl;
            frame_q.ip_header.protocol         <= ip_proto_udp;
            // Must be zero while the header words are summed
            frame_q.ip_header.header_checksum  <= '0;
            frame_q.ip_header.src_ip           <= req.endpoint.src_ip;
            frame_q.ip_header.dest_ip          <= req.endpoint.dest_ip;
            frame_q.udp_header.src_port        <= req.endpoint.src_port;
            frame_q.udp_header.dest_port       <= req.endpoint.dest_port;
            frame_q.udp_header.length          <= udp_length;
            // The UDP checksum is optional over IPv4 and zero means not used
            frame_q.udp_header.checksum        <= '0;
            frame_q.payload                    <= req.payload;
        end
        if (state == fb_sum) begin
            sum_q <= fold_sum;
        end
        if (state == fb_check) begin
            frame_q.ip_header.header_checksum <= ~sum_q;
        end
    end

endmodule

// ==== crc32_nibble.sv ====
`timescale 1ns/1ps

module crc32_nibble (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        nibble_valid,
    input  logic [3:0]  nibble,
    output logic [31:0] crc
);

    import udp_tx_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // Four single-bit steps of the reflected CRC, least significant data bit first
    always_comb begin
        crc_next = crc_q ^ {28'd0, nibble};
        for (int b = 0; b < 4; b++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ crc_polynomial;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    // A new frame starts from all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            crc_q <= '1;
        end else if (start) begin
            crc_q <= '1;
        end else if (nibble_valid) begin
            crc_q <= crc_next;
        end
    end

    // The caller complements this to form the FCS
    assign crc = crc_q;

endmodule

// ==== mii_serializer.sv ====
`timescale 1ns/1ps

module mii_serializer (
    input  logic               clk,
    input  logic               reset,
    input  udp_tx_pkg::frame_t frame,
    input  logic               frame_valid,
    output logic               frame_ready,
    input  logic               tx_clk,
    output logic               tx_en,
    output logic [3:0]         tx_d
);

    import udp_tx_pkg::*;

    typedef enum logic [2:0] {
        ms_idle,
        ms_preamble,
        ms_frame,
        ms_fcs,
        ms_gap
    } ms_state_t;

    ms_state_t                    state;
    logic [nibble_count_bits-1:0] count;
    frame_t                       frame_q;
    logic                         tx_clk_prev;
    logic                         tx_fall;
    logic                         take;
    logic [7:0]                   cur_byte;
    logic [3:0]                   cur_nibble;
    logic                         crc_valid;
    logic [31:0]                  crc;
    logic [31:0]                  fcs;

    // New frames are only taken between gaps
    assign frame_ready = (state == ms_idle);
    assign take = frame_valid && frame_ready;

    // tx_clk comes from the PHY and is only looked at once per system clock
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_clk_prev <= 1'b0;
        end else begin
            tx_clk_prev <= tx_clk;
        end
    end

    assign tx_fall = tx_clk_prev && !tx_clk;

    // The local copy is shifted one byte left after each high nibble, so the
    // byte on the wire is always the top one. Within a byte the low nibble goes first
    assign cur_byte = frame_q[$bits(frame_t)-1 -: 8];
    assign cur_nibble = count[0] ? cur_byte[7:4] : cur_byte[3:0];

    // Every frame nibble on the wire also goes into the CRC
    assign crc_valid = tx_fall && (state == ms_frame);
    assign fcs = ~crc;

    crc32_nibble u_crc (
        .clk          (clk),
        .reset        (reset),
        .start        (take),
        .nibble_valid (crc_valid),
        .nibble       (cur_nibble),
        .crc          (crc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ms_idle;
            count <= '0;
            tx_en <= 1'b0;
            tx_d  <= '0;
        end else begin
            case (state)
                ms_idle: begin
                    if (take) begin
                        state <= ms_preamble;
                        count <= '0;
                    end
                end
                ms_preamble: begin
                    // Nibble 0x5 on the MII bits gives the 1010 preamble on the line
                    if (tx_fall) begin
                        tx_en <= 1'b1;
                        if (count == nibble_count_bits'(preamble_nibbles - 1)) begin
                            tx_d  <= 4'hD;
                            count <= '0;
                            state <= ms_frame;
                        end else begin
                            tx_d  <= 4'h5;
                            count <= count + 1'b1;
                        end
                    end
                end
                ms_frame: begin
                    if (tx_fall) begin
                        tx_d <= cur_nibble;
                        if (count == nibble_count_bits'(frame_nibbles - 1)) begin
                            count <= '0;
                            state <= ms_fcs;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                ms_fcs: begin
                    // The last frame nibble went into the CRC several clocks ago,
                    // so the register is final by the first FCS edge
                    if (tx_fall) begin
                        if (count == nibble_count_bits'(8)) begin
                            // The edge after the last FCS nibble ends the frame
                            tx_en <= 1'b0;
                            tx_d  <= '0;
                            count <= '0;
                            state <= ms_gap;
                        end else begin
                            tx_d  <= fcs[4*count[2:0] +: 4];
                            count <= count + 1'b1;
                        end
                    end
                end
                ms_gap: begin
                    if (tx_fall) begin
                        if (count == nibble_count_bits'(gap_nibbles - 1)) begin
                            count <= '0;
                            state <= ms_idle;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: state <= ms_idle;
            endcase
        end
    end

    // Frame copy is loaded on the handshake and shifted as the bytes go out
    always_ff @(posedge clk) begin
        if (take) begin
            frame_q <= frame;
        end else if (crc_valid && count[0]) begin
            frame_q <= frame_q << 8;
        end
    end

endmodule

// ==== udp_tx_top.sv ====
`timescale 1ns/1ps

module udp_tx_top (
    input  logic                     clk,
    input  logic                     reset,
    input  udp_tx_pkg::udp_request_t req,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     tx_clk,
    output logic                     ref_clk,
    output logic                     tx_en,
    output logic [3:0]               tx_d
);

    import udp_tx_pkg::*;

    // Completed frame passed from the builder to the serializer
    frame_t frame;
    logic   frame_valid;
    logic   frame_ready;

    // Reference clock for the PHY, which returns tx_clk derived from it
    phy_clk_gen u_phy_clk_gen (
        .clk     (clk),
        .reset   (reset),
        .ref_clk (ref_clk)
    );

    // Fills in the headers and the IPv4 checksum
    frame_builder u_frame_builder (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    // Drives the MII transmit pins and appends the FCS
    mii_serializer u_mii_serializer (
        .clk         (clk),
        .reset       (reset),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .tx_clk      (tx_clk),
        .tx_en       (tx_en),
        .tx_d        (tx_d)
    );

endmodule

// ==== tb_udp_tx.sv ====
`timescale 1ns/1ps

module tb_udp_tx;

    import udp_tx_pkg::*;

    // Preamble with SFD, the frame itself, then four FCS bytes
    localparam int total_nibbles = preamble_nibbles + frame_nibbles + 8;
    localparam int wait_limit = 2000;

    logic         clk;
    logic         reset;
    udp_request_t req;
    logic         req_valid;
    logic         req_ready;
    logic         tx_clk;
    logic         ref_clk;
    logic         tx_en;
    logic [3:0]   tx_d;

    integer seed = 65892;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;

    // Nibbles seen on the wire, the nibble count of each frame and the idle time before it
    logic [3:0] rx_nibbles [$];
    int         rx_lengths [$];
    int         rx_gaps [$];
    int         last_end_cycle = 0;

    logic [7:0]  exp_bytes [0:frame_bytes-1];
    logic [3:0]  exp_nibbles [0:total_nibbles-1];
    logic [3:0]  rx_frame [0:total_nibbles-1];
    logic [15:0] exp_checksum;

    udp_tx_top DUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .tx_clk    (tx_clk),
        .ref_clk   (ref_clk),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    // The PHY model simply returns the reference clock as its transmit clock
    assign tx_clk = ref_clk;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Sampled on the falling system edge, where tx_en and tx_d are settled.
    // The DUT moves tx_d one clk after it sees tx_clk fall, which is what the
    // two-deep history of ref_clk picks out
    logic ref_seen_1 = 1'b0;
    logic ref_seen_2 = 1'b0;
    logic en_prev = 1'b0;
    logic had_frame = 1'b0;
    int   nibble_count = 0;
    int   gap_cycles = 0;

    always @(negedge clk) begin
        if (ref_seen_2 && !ref_seen_1 && tx_en) begin
            rx_nibbles.push_back(tx_d);
            nibble_count = nibble_count + 1;
        end
        if (tx_en && !en_prev && had_frame) begin
            rx_gaps.push_back(gap_cycles);
        end
        if (!tx_en && en_prev) begin
            rx_lengths.push_back(nibble_count);
            nibble_count = 0;
            gap_cycles = 0;
            last_end_cycle = cycle_count;
            had_frame = 1'b1;
        end
        if (!tx_en) begin
            gap_cycles = gap_cycles + 1;
        end
        en_prev = tx_en;
        ref_seen_2 = ref_seen_1;
        ref_seen_1 = ref_clk;
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("FAIL %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic expect_true(input logic cond, input string message);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("%s", message);
        end
    endtask

    task automatic random_request(output udp_request_t r);
        r.endpoint.src_ip = 32'($random(seed));
        r.endpoint.dest_ip = 32'($random(seed));
        r.endpoint.src_mac = {16'($random(seed)), 32'($random(seed))};
        r.endpoint.dest_mac = {16'($random(seed)), 32'($random(seed))};
        r.endpoint.src_port = 16'($random(seed));
        r.endpoint.dest_port = 16'($random(seed));
        for (int w = 0; w < payload_bytes / 4; w++) begin
            r.payload[32*w +: 32] = 32'($random(seed));
        end
    endtask

    // Ones' complement sum of the ten IPv4 header words with end-around carry
    function automatic logic [15:0] ip_checksum();
        logic [31:0] sum;
        sum = 32'h0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0, exp_bytes[14+2*i], exp_bytes[15+2*i]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // Standard Ethernet CRC-32 taken byte by byte, bits least significant first
    function automatic logic [31:0] frame_fcs();
        logic [31:0] crc;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < frame_bytes; i++) begin
            crc = crc ^ {24'h0, exp_bytes[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic build_expected(input udp_request_t r);
        logic [8*frame_bytes-1:0] flat;
        logic [31:0]              fcs;
        // Ethernet, IPv4 and UDP headers in wire order with zero checksums, then the payload
        flat = {r.endpoint.dest_mac, r.endpoint.src_mac, 16'h0800,
                8'h45, 8'h0C, 16'd44, 16'h0000, 16'h0000, 8'hFF, 8'h11, 16'h0000,
                r.endpoint.src_ip, r.endpoint.dest_ip,
                r.endpoint.src_port, r.endpoint.dest_port, 16'd24, 16'h0000,
                r.payload};
        for (int i = 0; i < frame_bytes; i++) begin
            exp_bytes[i] = flat[8*(frame_bytes-1-i) +: 8];
        end
        exp_checksum = ip_checksum();
        exp_bytes[24] = exp_checksum[15:8];
        exp_bytes[25] = exp_checksum[7:0];
        fcs = frame_fcs();
        for (int i = 0; i < preamble_nibbles - 1; i++) begin
            exp_nibbles[i] = 4'h5;
        end
        exp_nibbles[preamble_nibbles-1] = 4'hD;
        for (int b = 0; b < frame_bytes; b++) begin
            exp_nibbles[preamble_nibbles+2*b] = exp_bytes[b][3:0];
            exp_nibbles[preamble_nibbles+2*b+1] = exp_bytes[b][7:4];
        end
        for (int k = 0; k < 8; k++) begin
            exp_nibbles[preamble_nibbles+frame_nibbles+k] = fcs[4*k +: 4];
        end
    endtask

    // Called 1 ns after a rising edge; returns just before the transfer edge
    task automatic offer_request(input udp_request_t r, output int waited);
        req = r;
        req_valid = 1'b1;
        waited = 0;
        while (!req_ready && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        expect_true(req_ready, "Timed out waiting for req_ready");
    endtask

    task automatic send_request(input udp_request_t r);
        int waited;
        offer_request(r, waited);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic check_frame(input udp_request_t r, input string label);
        int waited;
        int length;
        logic [3:0] nibble;
        build_expected(r);
        waited = 0;
        while (rx_lengths.size() == 0 && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        expect_true(rx_lengths.size() != 0, $sformatf("Timed out waiting for frame %s", label));
        if (rx_lengths.size() != 0) begin
            length = rx_lengths.pop_front();
            expect_true(length == total_nibbles, $sformatf(
                "Frame %s carried %0d nibbles instead of %0d", label, length, total_nibbles));
            for (int i = 0; i < length; i++) begin
                nibble = rx_nibbles.pop_front();
                if (i < total_nibbles) begin
                    rx_frame[i] = nibble;
                    expect_value($sformatf("tx_d nibble %0d of frame %s", i, label),
                                 32'(nibble), 32'(exp_nibbles[i]));
                end
            end
        end
    endtask

    function automatic logic [7:0] rx_byte(input int b);
        return {rx_frame[preamble_nibbles+2*b+1], rx_frame[preamble_nibbles+2*b]};
    endfunction

    task automatic check_gaps(input int count);
        int gap;
        expect_true(rx_gaps.size() == count, "Wrong number of gaps between frames");
        while (rx_gaps.size() > 0) begin
            gap = rx_gaps.pop_front();
            expect_true(gap >= gap_nibbles * phy_divider,
                        $sformatf("Only %0d clk cycles with tx_en low between frames", gap));
        end
    endtask

    task automatic check_reset_state();
        logic prev;
        int   first;
        int   period;
        int   waited;
        expect_value("tx_en after reset", 32'(tx_en), 32'h0);
        expect_value("req_ready after reset", 32'(req_ready), 32'h1);
        expect_value("ref_clk after reset", 32'(ref_clk), 32'h0);
        prev = ref_clk;
        first = -1;
        period = -1;
        waited = 0;
        // Cycles between two rising edges of ref_clk
        while (period < 0 && waited < 50) begin
            @(posedge clk);
            #1;
            waited++;
            if (!prev && ref_clk) begin
                if (first < 0) begin
                    first = cycle_count;
                end else begin
                    period = cycle_count - first;
                end
            end
            prev = ref_clk;
        end
        expect_value("ref_clk period in clk cycles", 32'(period), 32'(phy_divider));
    endtask

    task automatic test_fixed_frame();
        udp_request_t r;
        r.endpoint.src_ip = 32'hC0A80001;
        r.endpoint.dest_ip = 32'hC0A800FE;
        r.endpoint.src_mac = 48'h001122334455;
        r.endpoint.dest_mac = 48'h0A1B2C3D4E5F;
        r.endpoint.src_port = 16'h1234;
        r.endpoint.dest_port = 16'h5678;
        r.payload = 128'h000102030405060708090A0B0C0D0E0F;
        send_request(r);
        check_frame(r, "fixed");
        expect_value("ip header_checksum", 32'({rx_byte(24), rx_byte(25)}), 32'(exp_checksum));
        expect_value("udp checksum", 32'({rx_byte(40), rx_byte(41)}), 32'h0);
    endtask

    task automatic test_back_to_back();
        udp_request_t reqs [0:2];
        for (int n = 0; n < 3; n++) begin
            random_request(reqs[n]);
        end
        for (int n = 0; n < 3; n++) begin
            send_request(reqs[n]);
        end
        for (int n = 0; n < 3; n++) begin
            check_frame(reqs[n], $sformatf("random %0d", n));
        end
        check_gaps(3);
    endtask

    // A second request goes in during a frame, the third must wait for the serializer
    task automatic test_overlap();
        udp_request_t a;
        udp_request_t b;
        udp_request_t c;
        int waited;
        random_request(a);
        random_request(b);
        random_request(c);
        send_request(a);
        waited = 0;
        while (!tx_en && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        expect_true(tx_en, "Timed out waiting for tx_en of the first overlap frame");
        send_request(b);
        expect_true(tx_en && rx_lengths.size() == 0,
                    "Second request was not accepted while the first frame was on the wire");
        offer_request(c, waited);
        expect_true(waited > 0, "Third request was accepted while the builder held a frame");
        expect_true(rx_lengths.size() == 1 &&
                    cycle_count - last_end_cycle >= gap_nibbles * phy_divider,
                    "req_ready rose before the serializer took the second frame");
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        check_frame(a, "overlap a");
        check_frame(b, "overlap b");
        check_frame(c, "overlap c");
        check_gaps(3);
    endtask

    initial begin
        req = '0;
        req_valid = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        test_fixed_frame();
        test_back_to_back();
        test_overlap();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
udp_tx_pkg.sv
phy_clk_gen.sv
frame_builder.sv
crc32_nibble.sv
mii_serializer.sv
udp_tx_top.sv
tb_udp_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
verilator --binary --timing --assert -f build.f --top-module tb_udp_tx -o sim_udp_tx &&
    ./obj_dir/sim_udp_tx | grep -F '*** PASSED ***' &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
